/* files.f */
+incdir+.
ats_pkg.sv
ats_frame_collector.sv
ats_flow_table.sv
ats_eligibility_calc.sv
ats_shaper.sv
ats_shaper_assertions.sv
ats_shaper_tb.sv

/* run.sh */
#!/bin/bash
# Build and run the ATS shaper testbench with Verilator

rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal --top-module ats_shaper_tb -f files.f \
  && ./obj_dir/Vats_shaper_tb > sim.log 2>&1 \
  || { cat sim.log 2>/dev/null; echo "Build or simulation did not complete"; exit 1; }

cat sim.log
grep -q "Finished with errors" sim.log && { echo "FAIL"; exit 1; }
grep -q "Finished with no errors" sim.log || { echo "FAIL: run ended early"; exit 1; }
echo "PASS"

/* ats_shaper_tb.sv */
// ----------------------------------------
// ATS shaper testbench
// Directed and random frames checked against a reference model
// ----------------------------------------

`timescale 1ns/1ps
`default_nettype none

`include "ats_settings.svh"

module ats_shaper_tb;

  import ats_pkg::*;

  localparam int WAIT_LIMIT = 400;

  logic         clk;
  logic         rstn;
  flow_id_t     flow_data;
  logic         flow_valid;
  logic         flow_ready;
  timestamp_t   arrival_data;
  logic         arrival_valid;
  logic         arrival_ready;
  frame_len_t   length_data;
  logic         length_valid;
  logic         length_ready;
  timestamp_t   elig_data;
  logic         elig_valid;
  logic         elig_ready;
  logic         cfg_wen;
  flow_id_t     cfg_flow;
  flow_params_t cfg_params;
  timestamp_t   max_residence_time;

  // Reference state per flow and the shared group time
  flow_params_t model_params [`ATS_FLOW_NUM];
  timestamp_t   model_bucket [`ATS_FLOW_NUM];
  timestamp_t   model_group;
  timestamp_t   expect_q [$];

  int         seed = 35685;
  int         errors;
  int         checks;
  int         test_errors;
  timestamp_t held;
  timestamp_t arrival;

  ats_shaper i_ats_shaper (.*);

  bind ats_shaper ats_shaper_assertions i_assertions (.*);

  always #50 clk = ~clk;

  // ----------------------------------------
  // Reference model
  // ----------------------------------------
  function automatic timestamp_t clip_sum(input timestamp_t a, input timestamp_t b);
    timestamp_t s;
    s = a + b;
    // A wrapped sum ends up below an operand
    if (s < a) begin
      s = '1;
    end
    return s;
  endfunction

  function automatic timestamp_t model_frame(input flow_id_t f, input timestamp_t arr,
                                             input frame_len_t len);
    timestamp_t rate;
    timestamp_t sched;
    timestamp_t full;
    timestamp_t elig;
    timestamp_t over;
    rate  = timestamp_t'(model_params[f].cir_inv);
    sched = clip_sum(model_bucket[f], timestamp_t'(len) * rate);
    full  = clip_sum(model_bucket[f], timestamp_t'(model_params[f].cbs) * rate);
    elig  = arr;
    if (model_group > elig) begin
      elig = model_group;
    end
    if (sched > elig) begin
      elig = sched;
    end
    // Too late to meet the residence limit
    if (elig > clip_sum(arr, max_residence_time)) begin
      return '0;
    end
    model_group = elig;
    over = clip_sum(sched, elig);
    if (elig < full) begin
      model_bucket[f] = sched;
    end else if (over > full) begin
      model_bucket[f] = over - full;
    end else begin
      model_bucket[f] = '0;
    end
    return elig;
  endfunction

  function automatic int rand_below(input int n);
    return int'({$random(seed)} % n);
  endfunction

  // ----------------------------------------
  // Stimulus tasks
  // ----------------------------------------
  task automatic set_params(input flow_id_t f, input commit_val_t rate, input commit_val_t burst);
    @(posedge clk);
    cfg_wen    <= 1'b1;
    cfg_flow   <= f;
    cfg_params <= '{cir_inv: rate, cbs: burst};
    @(posedge clk);
    cfg_wen <= 1'b0;
    model_params[f] = '{cir_inv: rate, cbs: burst};
  endtask

  task automatic set_residence(input timestamp_t t);
    max_residence_time <= t;
    @(posedge clk);
  endtask

  // Stream select 0 is flow, 1 arrival, 2 length
  task automatic wait_accept(input int which, input string name);
    logic ok;
    ok = 1'b0;
    for (int i = 0; i < WAIT_LIMIT && !ok; i++) begin
      @(posedge clk);
      case (which)
        0:       ok = flow_ready;
        1:       ok = arrival_ready;
        default: ok = length_ready;
      endcase
    end
    assert (ok) else begin
      $display("Timed out waiting for the %s stream to become ready", name);
      errors++;
    end
  endtask

  task automatic send_frame(input flow_id_t f, input timestamp_t arr, input frame_len_t len,
                            input int gap);
    expect_q.push_back(model_frame(f, arr, len));
    repeat (rand_below(gap + 1)) @(posedge clk);
    flow_valid <= 1'b1;
    flow_data  <= f;
    wait_accept(0, "flow");
    flow_valid <= 1'b0;
    repeat (rand_below(gap + 1)) @(posedge clk);
    arrival_valid <= 1'b1;
    arrival_data  <= arr;
    wait_accept(1, "arrival");
    arrival_valid <= 1'b0;
    repeat (rand_below(gap + 1)) @(posedge clk);
    length_valid <= 1'b1;
    length_data  <= len;
    wait_accept(2, "length");
    length_valid <= 1'b0;
  endtask

  task automatic wait_drained();
    int i;
    i = 0;
    while (expect_q.size() != 0 && i < WAIT_LIMIT) begin
      @(posedge clk);
      i++;
    end
    assert (expect_q.size() == 0) else begin
      $display("Timed out with %0d results still outstanding", expect_q.size());
      errors++;
      expect_q.delete();
    end
  endtask

  task automatic end_test(input string name);
    wait_drained();
    $display("Test %s done, %0d errors", name, errors - test_errors);
    test_errors = errors;
  endtask

  // ----------------------------------------
  // Result checker
  // ----------------------------------------
  always @(posedge clk) begin
    if (rstn && elig_valid && elig_ready) begin
      checks++;
      assert (expect_q.size() != 0) else begin
        $display("Result 0x%0h appeared with no frame outstanding", elig_data);
        errors++;
      end
      if (expect_q.size() != 0) begin
        assert (elig_data == expect_q[0]) else begin
          $display("mismatch at %0d ns: elig_data 0x%0h, expected 0x%0h",
                   $time, elig_data, expect_q[0]);
          errors++;
        end
        void'(expect_q.pop_front());
      end
    end
  end

  initial begin
    clk                = 1'b0;
    rstn               = 1'b0;
    flow_data          = '0;
    flow_valid         = 1'b0;
    arrival_data       = '0;
    arrival_valid      = 1'b0;
    length_data        = '0;
    length_valid       = 1'b0;
    elig_ready         = 1'b1;
    cfg_wen            = 1'b0;
    cfg_flow           = '0;
    cfg_params         = '0;
    max_residence_time = 72'd1_000_000_000;
    errors             = 0;
    checks             = 0;
    test_errors        = 0;
    model_group        = '0;
    for (int i = 0; i < `ATS_FLOW_NUM; i++) begin
      model_params[i] = '0;
      model_bucket[i] = '0;
    end
    repeat (3) @(posedge clk);
    rstn <= 1'b1;
    @(posedge clk);

    // Empty buckets so length duration or arrival wins
    set_params(4'd1, 32'd8, 32'd4000);
    set_params(4'd0, 32'd16, 32'd2000);
    send_frame(4'd1, 72'd5000, 16'd1000, 0);
    send_frame(4'd0, 72'd20000, 16'd100, 0);
    end_test("first_frame");

    for (int k = 0; k < 4; k++) begin
      send_frame(4'd1, timestamp_t'(100000 + k * 100), 16'd1500, 0);
    end
    // Late frame lands beyond bucket-full
    send_frame(4'd1, 72'd500000, 16'd1500, 0);
    send_frame(4'd1, 72'd500050, 16'd1500, 0);
    end_test("bucket_accumulation");

    set_params(4'd2, 32'd10, 32'd3000);
    set_params(4'd3, 32'd40, 32'd1000);
    for (int k = 0; k < 6; k++) begin
      send_frame(flow_id_t'(2 + k % 2), timestamp_t'(5_000_000 + k * 2000), 16'd1200, 0);
    end
    end_test("two_flows");

    set_params(4'd5, 32'd1000, 32'd2000);
    set_residence(72'd5000);
    send_frame(4'd5, 72'd10_000_000, 16'd1500, 0);
    send_frame(4'd5, 72'd10_001_000, 16'd1500, 0);
    wait_drained();
    set_residence(72'd1_000_000_000);
    send_frame(4'd5, 72'd10_002_000, 16'd1500, 0);
    end_test("residence_discard");

    // Output stalled while the second frame parks in the collector
    set_params(4'd6, 32'd20, 32'd5000);
    elig_ready <= 1'b0;
    send_frame(4'd6, 72'd20_000_000, 16'd800, 0);
    send_frame(4'd6, 72'd20_000_100, 16'd800, 0);
    for (int i = 0; i < WAIT_LIMIT && !elig_valid; i++) begin
      @(posedge clk);
    end
    assert (elig_valid) else begin
      $display("Timed out waiting for a result while elig_ready was low");
      errors++;
    end
    held = elig_data;
    flow_valid <= 1'b1;
    flow_data  <= 4'd6;
    repeat (8) begin
      @(posedge clk);
      assert (!flow_ready) else begin
        $display("Flow stream accepted data while a result was held");
        errors++;
      end
      assert (elig_valid && elig_data == held) else begin
        $display("mismatch at %0d ns: held result 0x%0h became 0x%0h", $time, held, elig_data);
        errors++;
      end
    end
    flow_valid <= 1'b0;
    elig_ready <= 1'b1;
    send_frame(4'd6, 72'd20_000_200, 16'd800, 0);
    end_test("backpressure");

    for (int f = 8; f < 12; f++) begin
      set_params(flow_id_t'(f), commit_val_t'(1 + rand_below(100)),
                 commit_val_t'(500 + rand_below(8000)));
    end
    arrival = 72'd30_000_000;
    for (int k = 0; k < 60; k++) begin
      if (rand_below(4) == 0) begin
        wait_drained();
        set_params(flow_id_t'(8 + rand_below(4)), commit_val_t'(1 + rand_below(100)),
                   commit_val_t'(500 + rand_below(8000)));
      end
      arrival = arrival + timestamp_t'(rand_below(40000));
      send_frame(flow_id_t'(8 + rand_below(4)), arrival, frame_len_t'(64 + rand_below(1437)), 3);
    end
    end_test("random");

    $display("Tests run: 6, results checked: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* ats_shaper_assertions.sv */
// ----------------------------------------
// ATS shaper stream checks
// Handshake rules on the top-level streams
// ----------------------------------------

`timescale 1ns/1ps
`default_nettype none

module ats_shaper_assertions (
  input logic                clk,
  input logic                rstn,
  input logic                flow_ready,
  input logic                arrival_ready,
  input logic                length_ready,
  input ats_pkg::timestamp_t elig_data,
  input logic                elig_valid,
  input logic                elig_ready
);

  // Stalled result holds until taken
  elig_stable_a: assert property (
    @(posedge clk) disable iff (!rstn)
    (elig_valid && !elig_ready) |=> (elig_valid && $stable(elig_data))
  ) else $error("elig_data or elig_valid changed while the output was stalled");

  // Flow stream is the collector's idle state and stays ready in reset
  reset_quiet_a: assert property (
    @(posedge clk)
    (!rstn && $past(!rstn)) |-> (!arrival_ready && !length_ready && !elig_valid)
  ) else $error("A ready or valid output was high during reset");

  // Collector offers one input stream at a time
  one_ready_a: assert property (
    @(posedge clk) disable iff (!rstn)
    $onehot0({flow_ready, arrival_ready, length_ready})
  ) else $error("More than one input stream was ready at once");

endmodule

`default_nettype wire

/* ats_shaper.sv */
// ----------------------------------------
// ATS shaper top level
// Collector, flow table and eligibility calculator
// ----------------------------------------

`timescale 1ns/1ps
`default_nettype none

module ats_shaper (
  input  logic                  clk,
  input  logic                  rstn,
  input  ats_pkg::flow_id_t     flow_data,
  input  logic                  flow_valid,
  output logic                  flow_ready,
  input  ats_pkg::timestamp_t   arrival_data,
  input  logic                  arrival_valid,
  output logic                  arrival_ready,
  input  ats_pkg::frame_len_t   length_data,
  input  logic                  length_valid,
  output logic                  length_ready,
  output ats_pkg::timestamp_t   elig_data,
  output logic                  elig_valid,
  input  logic                  elig_ready,
  input  logic                  cfg_wen,
  input  ats_pkg::flow_id_t     cfg_flow,
  input  ats_pkg::flow_params_t cfg_params,
  input  ats_pkg::timestamp_t   max_residence_time
);

  import ats_pkg::*;

  frame_desc_t  desc;
  logic         desc_valid;
  logic         desc_take;
  logic         rd_en;
  flow_id_t     rd_flow;
  flow_params_t params;
  timestamp_t   bucket_empty;
  logic         wb_en;
  flow_id_t     wb_flow;
  timestamp_t   wb_bucket_empty;

  ats_frame_collector i_collector (
    .clk           (clk),
    .rstn          (rstn),
    .flow_data     (flow_data),
    .flow_valid    (flow_valid),
    .flow_ready    (flow_ready),
    .arrival_data  (arrival_data),
    .arrival_valid (arrival_valid),
    .arrival_ready (arrival_ready),
    .length_data   (length_data),
    .length_valid  (length_valid),
    .length_ready  (length_ready),
    .desc          (desc),
    .desc_valid    (desc_valid),
    .desc_take     (desc_take)
  );

  ats_flow_table i_table (
    .clk             (clk),
    .rstn            (rstn),
    .cfg_wen         (cfg_wen),
    .cfg_flow        (cfg_flow),
    .cfg_params      (cfg_params),
    .rd_en           (rd_en),
    .rd_flow         (rd_flow),
    .params          (params),
    .bucket_empty    (bucket_empty),
    .wb_en           (wb_en),
    .wb_flow         (wb_flow),
    .wb_bucket_empty (wb_bucket_empty)
  );

  ats_eligibility_calc i_calc (
    .clk                (clk),
    .rstn               (rstn),
    .desc               (desc),
    .desc_valid         (desc_valid),
    .desc_take          (desc_take),
    .max_residence_time (max_residence_time),
    .rd_en              (rd_en),
    .rd_flow            (rd_flow),
    .params             (params),
    .bucket_empty       (bucket_empty),
    .wb_en              (wb_en),
    .wb_flow            (wb_flow),
    .wb_bucket_empty    (wb_bucket_empty),
    .elig_data          (elig_data),
    .elig_valid         (elig_valid),
    .elig_ready         (elig_ready)
  );

endmodule

`default_nettype wire

/* ats_eligibility_calc.sv */
// ----------------------------------------
// ATS eligibility calculator
// Computes eligibility time, applies residence limit, updates buckets
// ----------------------------------------

`timescale 1ns/1ps
`default_nettype none

`include "ats_settings.svh"

module ats_eligibility_calc (
  input  logic                  clk,
  input  logic                  rstn,
  input  ats_pkg::frame_desc_t  desc,
  input  logic                  desc_valid,
  output logic                  desc_take,
  input  ats_pkg::timestamp_t   max_residence_time,
  output logic                  rd_en,
  output ats_pkg::flow_id_t     rd_flow,
  input  ats_pkg::flow_params_t params,
  input  ats_pkg::timestamp_t   bucket_empty,
  output logic                  wb_en,
  output ats_pkg::flow_id_t     wb_flow,
  output ats_pkg::timestamp_t   wb_bucket_empty,
  output ats_pkg::timestamp_t   elig_data,
  output logic                  elig_valid,
  input  logic                  elig_ready
);

  import ats_pkg::*;

  calc_state_t state;
  frame_desc_t frame;
  timestamp_t  group_time;
  timestamp_t  len_dur;
  timestamp_t  burst_dur;
  timestamp_t  sched_time;
  timestamp_t  full_time;
  timestamp_t  limit_time;
  timestamp_t  elig_time;
  timestamp_t  excess_time;
  logic        pass;

  logic [`ATS_LENGTH_WIDTH+`ATS_COMMIT_WIDTH-1:0] len_prod;
  logic [2*`ATS_COMMIT_WIDTH-1:0]                 burst_prod;

  // Sum clipped to all ones
  function automatic timestamp_t sat_add(input timestamp_t a, input timestamp_t b);
    logic [`ATS_TIMESTAMP_WIDTH:0] sum;
    sum = {1'b0, a} + {1'b0, b};
    return sum[`ATS_TIMESTAMP_WIDTH] ? `ATS_TIMESTAMP_MAX : sum[`ATS_TIMESTAMP_WIDTH-1:0];
  endfunction

  // Table read issued in the cycle the descriptor is taken
  assign desc_take = (state == CALC_IDLE) && desc_valid;
  assign rd_en     = desc_take;
  assign rd_flow   = desc.flow;

  assign len_prod   = frame.length * params.cir_inv;
  assign burst_prod = params.cbs * params.cir_inv;

  assign pass        = (elig_time <= limit_time);
  assign excess_time = sat_add(sched_time, elig_time);

  // New bucket-empty time, excess beyond bucket-full is carried over
  always_comb begin
    if (elig_time < full_time) begin
      wb_bucket_empty = sched_time;
    end else if (excess_time > full_time) begin
      wb_bucket_empty = excess_time - full_time;
    end else begin
      wb_bucket_empty = `ATS_TIMESTAMP_MIN;
    end
  end

  assign wb_en   = (state == CALC_DECIDE) && pass;
  assign wb_flow = frame.flow;

  assign elig_data  = elig_time;
  assign elig_valid = (state == CALC_OUTPUT);

  // --------------------------------------
  // Control: state and shared group time
  // --------------------------------------
  always_ff @(posedge clk) begin
    if (!rstn) begin
      state      <= CALC_IDLE;
      group_time <= `ATS_TIMESTAMP_MIN;
    end else begin
      case (state)
        CALC_IDLE:   if (desc_take) state <= CALC_LOAD;
        CALC_LOAD:   state <= CALC_SUMS;
        CALC_SUMS:   state <= CALC_MAX;
        CALC_MAX:    state <= CALC_DECIDE;
        CALC_DECIDE: begin
          if (pass) begin
            group_time <= elig_time;
          end
          state <= CALC_OUTPUT;
        end
        CALC_OUTPUT: if (elig_ready) state <= CALC_IDLE;
        default:     state <= CALC_IDLE;
      endcase
    end
  end

  // --------------------------------------
  // Datapath, one step per state
  // --------------------------------------
  always_ff @(posedge clk) begin
    case (state)
      CALC_IDLE: begin
        if (desc_take) begin
          frame <= desc;
        end
      end
      CALC_LOAD: begin
        len_dur   <= timestamp_t'(len_prod);
        burst_dur <= timestamp_t'(burst_prod);
      end
      CALC_SUMS: begin
        sched_time <= sat_add(bucket_empty, len_dur);
        full_time  <= sat_add(bucket_empty, burst_dur);
        limit_time <= sat_add(frame.arrival, max_residence_time);
      end
      CALC_MAX: begin
        if (frame.arrival >= group_time && frame.arrival >= sched_time) begin
          elig_time <= frame.arrival;
        end else if (group_time >= sched_time) begin
          elig_time <= group_time;
        end else begin
          elig_time <= sched_time;
        end
      end
      CALC_DECIDE: begin
        // Zero marks a discarded frame
        if (!pass) begin
          elig_time <= `ATS_TIMESTAMP_MIN;
        end
      end
      default: begin
      end
    endcase
  end

endmodule

`default_nettype wire

/* ats_flow_table.sv */
// ----------------------------------------
// ATS per-flow table
// Rate and burst parameters plus bucket-empty time per flow
// ----------------------------------------

`timescale 1ns/1ps
`default_nettype none

`include "ats_settings.svh"

module ats_flow_table (
  input  logic                  clk,
  input  logic                  rstn,
  // Configuration write port
  input  logic                  cfg_wen,
  input  ats_pkg::flow_id_t     cfg_flow,
  input  ats_pkg::flow_params_t cfg_params,
  // Calculator read port
  input  logic                  rd_en,
  input  ats_pkg::flow_id_t     rd_flow,
  output ats_pkg::flow_params_t params,
  output ats_pkg::timestamp_t   bucket_empty,
  // Bucket write-back port
  input  logic                  wb_en,
  input  ats_pkg::flow_id_t     wb_flow,
  input  ats_pkg::timestamp_t   wb_bucket_empty
);

  import ats_pkg::*;

  flow_params_t param_mem [`ATS_FLOW_NUM];
  timestamp_t   bucket_mem [`ATS_FLOW_NUM];

  // --------------------------------------
  // Parameter array, written by configuration only
  // --------------------------------------
  always_ff @(posedge clk) begin
    if (!rstn) begin
      for (int i = 0; i < `ATS_FLOW_NUM; i++) begin
        param_mem[i] <= '0;
      end
    end else if (cfg_wen) begin
      param_mem[cfg_flow] <= cfg_params;
    end
  end

  // --------------------------------------
  // Bucket array, written back by the calculator
  // --------------------------------------
  always_ff @(posedge clk) begin
    if (!rstn) begin
      for (int i = 0; i < `ATS_FLOW_NUM; i++) begin
        bucket_mem[i] <= `ATS_TIMESTAMP_MIN;
      end
    end else if (wb_en) begin
      bucket_mem[wb_flow] <= wb_bucket_empty;
    end
  end

  // --------------------------------------
  // Registered read, one cycle latency
  // --------------------------------------
  // Outputs hold between reads so the calculator
  // can use them over several steps
  always_ff @(posedge clk) begin
    if (rd_en) begin
      params       <= param_mem[rd_flow];
      bucket_empty <= bucket_mem[rd_flow];
    end
  end

endmodule

`default_nettype wire

/* ats_frame_collector.sv */
// ----------------------------------------
// ATS frame descriptor collector
// Takes flow, arrival and length in order, holds one descriptor
// ----------------------------------------

`timescale 1ns/1ps
`default_nettype none

module ats_frame_collector (
  input  logic                 clk,
  input  logic                 rstn,
  input  ats_pkg::flow_id_t    flow_data,
  input  logic                 flow_valid,
  output logic                 flow_ready,
  input  ats_pkg::timestamp_t  arrival_data,
  input  logic                 arrival_valid,
  output logic                 arrival_ready,
  input  ats_pkg::frame_len_t  length_data,
  input  logic                 length_valid,
  output logic                 length_ready,
  output ats_pkg::frame_desc_t desc,
  output logic                 desc_valid,
  input  logic                 desc_take
);

  typedef enum logic [1:0] {
    COL_FLOW,
    COL_ARRIVAL,
    COL_LENGTH,
    COL_HOLD
  } col_state_t;

  col_state_t state;
  logic       flow_xfer;
  logic       arrival_xfer;
  logic       length_xfer;

  // One stream ready at a time
  assign flow_ready    = (state == COL_FLOW);
  assign arrival_ready = (state == COL_ARRIVAL);
  assign length_ready  = (state == COL_LENGTH);
  assign desc_valid    = (state == COL_HOLD);

  assign flow_xfer    = flow_valid && flow_ready;
  assign arrival_xfer = arrival_valid && arrival_ready;
  assign length_xfer  = length_valid && length_ready;

  always_ff @(posedge clk) begin
    if (!rstn) begin
      state <= COL_FLOW;
    end else begin
      case (state)
        COL_FLOW:    if (flow_xfer) state <= COL_ARRIVAL;
        COL_ARRIVAL: if (arrival_xfer) state <= COL_LENGTH;
        COL_LENGTH:  if (length_xfer) state <= COL_HOLD;
        // Released as soon as the calculator latches it
        COL_HOLD:    if (desc_take) state <= COL_FLOW;
        default:     state <= COL_FLOW;
      endcase
    end
  end

  // Descriptor fields, each written on its own transfer
  always_ff @(posedge clk) begin
    if (flow_xfer) begin
      desc.flow <= flow_data;
    end
    if (arrival_xfer) begin
      desc.arrival <= arrival_data;
    end
    if (length_xfer) begin
      desc.length <= length_data;
    end
  end

endmodule

`default_nettype wire

/* ats_pkg.sv */
// ----------------------------------------
// ATS shaper types
// Vector typedefs, descriptor structs, calculator states
// ----------------------------------------

`default_nettype none

`include "ats_settings.svh"

package ats_pkg;

  typedef logic [`ATS_FLOW_WIDTH-1:0] flow_id_t;
  // Arrival, eligibility, durations and bucket times
  typedef logic [`ATS_TIMESTAMP_WIDTH-1:0] timestamp_t;
  typedef logic [`ATS_LENGTH_WIDTH-1:0] frame_len_t;
  typedef logic [`ATS_COMMIT_WIDTH-1:0] commit_val_t;

  // One frame as seen by the calculator
  typedef struct packed {
    flow_id_t   flow;
    timestamp_t arrival;
    frame_len_t length;
  } frame_desc_t;

  // Per-flow shaping parameters
  typedef struct packed {
    commit_val_t cir_inv;
    commit_val_t cbs;
  } flow_params_t;

  typedef enum logic [2:0] {
    CALC_IDLE,
    CALC_LOAD,
    CALC_SUMS,
    CALC_MAX,
    CALC_DECIDE,
    CALC_OUTPUT
  } calc_state_t;

endpackage

`default_nettype wire

/* ats_settings.svh */
// ----------------------------------------
// ATS shaper settings
// Flow count, field widths and saturation limits
// ----------------------------------------

`ifndef ATS_SETTINGS_SVH
`define ATS_SETTINGS_SVH

// Flow table size
`define ATS_FLOW_NUM 16
`define ATS_FLOW_WIDTH 4

// Time in ps, length in bytes
`define ATS_TIMESTAMP_WIDTH 72
`define ATS_LENGTH_WIDTH 16

// Rate inverse (ps per byte) and burst size (bytes)
`define ATS_COMMIT_WIDTH 32

// Saturation bounds for time arithmetic
`define ATS_TIMESTAMP_MAX {`ATS_TIMESTAMP_WIDTH{1'b1}}
`define ATS_TIMESTAMP_MIN {`ATS_TIMESTAMP_WIDTH{1'b0}}

`endif
